// ==== Bender.yml ====
package:
  name: oam_dma_copy

sources:
  # package first, then the rtl blocks and the top level
  - source/dma_pkg.sv
  - source/oam_dma.sv
  - source/work_ram.sv
  - source/oam_ram.sv
  - source/dma_top.sv

  # testbench and bound checker
  - target: test
    files:
      - verif/dma_assertions.sv
      - verif/dma_tb.sv

// ==== source/dma_pkg.sv ====
package dma_pkg;

  // ==========================================================================
  // memory map
  // ==========================================================================

  // start register, write a source page here to kick off a copy
  localparam logic [15:0] dma_reg_addr = 16'hFF46;

  // object attribute memory sits at FE00..FE9F
  localparam logic [7:0] oam_page   = 8'hFE;
  localparam logic [7:0] oam_length = 8'd160;

  // work ram pages, 8 KiB total
  localparam logic [7:0] wram_first_page = 8'hC0;
  localparam logic [7:0] wram_last_page  = 8'hDF;

  // clock phases spent on every copied byte
  localparam int cycles_per_byte = 4;

  // cpu sees this on oam and work ram while a copy runs
  localparam logic [7:0] blocked_read_value = 8'hFF;

  // ==========================================================================
  // types
  // ==========================================================================

  // one phase per clock, t1 read, t2 capture, t3 write, t4 advance
  typedef enum logic [1:0] {
    t1,
    t2,
    t3,
    t4
  } dma_phase_t;

  // 16-bit bus address, flat or as page and offset
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] page;
      logic [7:0] offset;
    } split;
  } bus_addr_t;

endpackage

// ==== source/dma_top.sv ====
`timescale 1ns/100ps

module dma_top (
  input  logic               clk,
  input  logic               reset,
  input  dma_pkg::bus_addr_t cpu_addr,
  input  logic [7:0]         cpu_wdata,
  input  logic               cpu_write_en,
  input  logic               cpu_read_en,
  output logic [7:0]         cpu_rdata,
  output logic               dma_active
);

  import dma_pkg::*;

  // copy path between the three blocks
  bus_addr_t  dma_addr;
  logic       dma_read_en;
  logic       dma_write_en;
  logic [7:0] dma_wdata;
  logic [7:0] dma_rdata;

  // per-target read data, zero when not addressed
  logic [7:0] reg_cpu_rdata;
  logic [7:0] wram_cpu_rdata;
  logic [7:0] oam_cpu_rdata;

  oam_dma u_oam_dma (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_write_en (cpu_write_en),
    .cpu_read_en  (cpu_read_en),
    .cpu_rdata    (reg_cpu_rdata),
    .dma_addr     (dma_addr),
    .dma_read_en  (dma_read_en),
    .dma_write_en (dma_write_en),
    .dma_wdata    (dma_wdata),
    .dma_rdata    (dma_rdata),
    .dma_active   (dma_active)
  );

  work_ram u_work_ram (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_write_en (cpu_write_en),
    .cpu_read_en  (cpu_read_en),
    .cpu_rdata    (wram_cpu_rdata),
    .dma_addr     (dma_addr),
    .dma_read_en  (dma_read_en),
    .dma_active   (dma_active),
    .dma_rdata    (dma_rdata)
  );

  oam_ram u_oam_ram (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_write_en (cpu_write_en),
    .cpu_read_en  (cpu_read_en),
    .cpu_rdata    (oam_cpu_rdata),
    .dma_addr     (dma_addr),
    .dma_wdata    (dma_wdata),
    .dma_write_en (dma_write_en),
    .dma_active   (dma_active)
  );

  // ranges do not overlap so a plain OR merges the read data
  assign cpu_rdata = reg_cpu_rdata | wram_cpu_rdata | oam_cpu_rdata;

endmodule

// ==== source/oam_dma.sv ====
`timescale 1ns/100ps

module oam_dma (
  input  logic               clk,
  input  logic               reset,

  // cpu side, only the start register lives here
  input  dma_pkg::bus_addr_t cpu_addr,
  input  logic [7:0]         cpu_wdata,
  input  logic               cpu_write_en,
  input  logic               cpu_read_en,
  output logic [7:0]         cpu_rdata,

  // copy side towards work ram and oam
  output dma_pkg::bus_addr_t dma_addr,
  output logic               dma_read_en,
  output logic               dma_write_en,
  output logic [7:0]         dma_wdata,
  input  logic [7:0]         dma_rdata,
  output logic               dma_active
);

  import dma_pkg::*;

  // source page, reads back on FF46
  logic [7:0] src_page;

  // byte index 0..159
  logic [7:0] dma_index;
  dma_phase_t phase;

  logic      reg_sel;
  logic      start;
  logic      last_byte;
  bus_addr_t read_addr;
  bus_addr_t write_addr;

  assign reg_sel   = cpu_addr.word == dma_reg_addr;
  assign start     = cpu_write_en && reg_sel;
  assign last_byte = dma_index == oam_length - 8'd1;

  // source is page:index, destination FE:index
  assign read_addr.word  = {src_page, dma_index};
  assign write_addr.word = {oam_page, dma_index};

  // ==========================================================================
  // start register read back
  // ==========================================================================
  always_comb begin
    cpu_rdata = 8'h00;
    if (cpu_read_en && reg_sel) begin
      cpu_rdata = src_page;
    end
  end

  // ==========================================================================
  // phase sequencer
  // ==========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      src_page     <= 8'h00;
      dma_index    <= 8'd0;
      phase        <= t1;
      dma_active   <= 1'b0;
      dma_read_en  <= 1'b0;
      dma_write_en <= 1'b0;
    end else if (start) begin
      // also a restart when a copy is already running
      src_page     <= cpu_wdata;
      dma_index    <= 8'd0;
      phase        <= t1;
      dma_active   <= 1'b1;
      dma_read_en  <= 1'b0;
      dma_write_en <= 1'b0;
    end else if (dma_active) begin
      unique case (phase)
        t1: begin
          // read address goes out with read_en
          dma_read_en  <= 1'b1;
          dma_write_en <= 1'b0;
          phase        <= t2;
        end
        t2: begin
          // byte is captured, switch to writing
          dma_read_en  <= 1'b0;
          dma_write_en <= 1'b1;
          phase        <= t3;
        end
        t3: begin
          // oam takes the byte on this edge
          phase <= t4;
        end
        t4: begin
          dma_write_en <= 1'b0;
          phase        <= t1;
          if (last_byte) begin
            dma_active <= 1'b0;
            dma_index  <= 8'd0;
          end else begin
            dma_index <= dma_index + 8'd1;
          end
        end
      endcase
    end
  end

  // ==========================================================================
  // address and in-flight byte
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (dma_active && !start) begin
      if (phase == t1) begin
        dma_addr <= read_addr;
      end else if (phase == t2) begin
        // the one byte held between read and write
        dma_addr  <= write_addr;
        dma_wdata <= dma_rdata;
      end
    end
  end

endmodule

// ==== source/oam_ram.sv ====
`timescale 1ns/100ps

module oam_ram (
  input  logic               clk,
  input  logic               reset,

  // cpu port
  input  dma_pkg::bus_addr_t cpu_addr,
  input  logic [7:0]         cpu_wdata,
  input  logic               cpu_write_en,
  input  logic               cpu_read_en,
  output logic [7:0]         cpu_rdata,

  // dma write port
  input  dma_pkg::bus_addr_t dma_addr,
  input  logic [7:0]         dma_wdata,
  input  logic               dma_write_en,
  input  logic               dma_active
);

  import dma_pkg::*;

  // FE00..FE9F
  logic [7:0] mem [oam_length];

  logic cpu_sel;
  logic dma_sel;

  assign cpu_sel = cpu_addr.split.page == oam_page &&
                   cpu_addr.split.offset < oam_length;
  assign dma_sel = dma_addr.split.page == oam_page &&
                   dma_addr.split.offset < oam_length;

  // ==========================================================================
  // write side
  // ==========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < oam_length; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (dma_write_en && dma_sel) begin
      // dma wins over the cpu
      mem[dma_addr.split.offset] <= dma_wdata;
    end else if (cpu_write_en && cpu_sel && !dma_active) begin
      mem[cpu_addr.split.offset] <= cpu_wdata;
    end
  end

  // ==========================================================================
  // cpu read side
  // ==========================================================================
  always_comb begin
    cpu_rdata = 8'h00;
    if (cpu_read_en && cpu_sel) begin
      if (dma_active) begin
        cpu_rdata = blocked_read_value;
      end else begin
        cpu_rdata = mem[cpu_addr.split.offset];
      end
    end
  end

endmodule

// ==== source/work_ram.sv ====
`timescale 1ns/100ps

module work_ram (
  input  logic               clk,
  input  logic               reset,
  input  dma_pkg::bus_addr_t cpu_addr,
  input  logic [7:0]         cpu_wdata,
  input  logic               cpu_write_en,
  input  logic               cpu_read_en,
  output logic [7:0]         cpu_rdata,
  input  dma_pkg::bus_addr_t dma_addr,
  input  logic               dma_read_en,
  input  logic               dma_active,
  output logic [7:0]         dma_rdata
);

  import dma_pkg::*;

  // C000..DFFF, 8 KiB
  logic [7:0] mem [(wram_last_page - wram_first_page + 1) * 256];

  logic        cpu_sel;
  logic        dma_sel;
  logic [7:0]  cpu_page_rel;
  logic [7:0]  dma_page_rel;
  logic [12:0] cpu_index;
  logic [12:0] dma_index;

  assign cpu_sel = cpu_addr.split.page >= wram_first_page &&
                   cpu_addr.split.page <= wram_last_page;
  assign dma_sel = dma_addr.split.page >= wram_first_page &&
                   dma_addr.split.page <= wram_last_page;

  assign cpu_page_rel = cpu_addr.split.page - wram_first_page;
  assign dma_page_rel = dma_addr.split.page - wram_first_page;
  assign cpu_index    = {cpu_page_rel[4:0], cpu_addr.split.offset};
  assign dma_index    = {dma_page_rel[4:0], dma_addr.split.offset};

  // cpu writes are dropped while a copy owns the bus
  always_ff @(posedge clk) begin
    if (!reset && cpu_write_en && cpu_sel && !dma_active) begin
      mem[cpu_index] <= cpu_wdata;
    end
  end

  assign cpu_rdata = !(cpu_read_en && cpu_sel) ? 8'h00 :
                     dma_active                ? blocked_read_value :
                                                 mem[cpu_index];

  // pages outside work ram read as zero
  assign dma_rdata = (dma_read_en && dma_sel) ? mem[dma_index] : 8'h00;

endmodule

// ==== tb.f ====
source/dma_pkg.sv
source/oam_dma.sv
source/work_ram.sv
source/oam_ram.sv
source/dma_top.sv
verif/dma_assertions.sv
verif/dma_tb.sv

// ==== verif/dma_assertions.sv ====
`timescale 1ns/100ps

module dma_assertions (
  input logic               clk,
  input logic               reset,
  input dma_pkg::bus_addr_t cpu_addr,
  input logic [7:0]         cpu_wdata,
  input logic               cpu_write_en,
  input logic               cpu_read_en,
  input logic [7:0]         cpu_rdata,
  input logic               dma_active
);

  import dma_pkg::*;

  localparam int copy_cycles = oam_length * cycles_per_byte;

  // failed checks so far, watched by the testbench
  int error_count = 0;

  // shadow of cpu writes into work ram
  logic [7:0] shadow [(wram_last_page - wram_first_page + 1) * 256];

  logic [7:0] last_page;
  int         cycles_left;
  logic       copy_done;
  logic       start_write;
  logic       reg_read;
  logic       in_wram;
  logic       in_oam;
  logic [7:0] cpu_page_rel;
  logic [7:0] src_page_rel;
  logic [7:0] expected_oam;
  dma_phase_t expected_phase;

  assign start_write  = cpu_write_en && cpu_addr.word == dma_reg_addr;
  assign reg_read     = cpu_read_en && cpu_addr.word == dma_reg_addr;
  assign in_wram      = cpu_addr.split.page >= wram_first_page &&
                        cpu_addr.split.page <= wram_last_page;
  assign in_oam       = cpu_addr.split.page == oam_page &&
                        cpu_addr.split.offset < oam_length;
  assign cpu_page_rel = cpu_addr.split.page - wram_first_page;
  assign src_page_rel = last_page - wram_first_page;

  // four phases per byte, starting at t1 on the start edge
  assign expected_phase = dma_phase_t'(2'(copy_cycles - cycles_left));

  // oam byte i should be the source page byte i, pages outside work ram read 0
  always_comb begin
    expected_oam = 8'h00;
    if (last_page >= wram_first_page && last_page <= wram_last_page) begin
      expected_oam = shadow[{src_page_rel[4:0], cpu_addr.split.offset}];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset && cpu_write_en && in_wram && !dma_active) begin
      shadow[{cpu_page_rel[4:0], cpu_addr.split.offset}] <= cpu_wdata;
    end
  end

  // ==========================================================================
  // reference copy timing
  // ==========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      last_page   <= 8'h00;
      cycles_left <= 0;
      copy_done   <= 1'b0;
    end else if (start_write) begin
      // a restart begins the full count again
      last_page   <= cpu_wdata;
      cycles_left <= copy_cycles;
      copy_done   <= 1'b0;
    end else if (cycles_left != 0) begin
      cycles_left <= cycles_left - 1;
      if (cycles_left == 1) begin
        copy_done <= 1'b1;
      end
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  reg_readback: assert property (@(posedge clk) disable iff (reset)
    reg_read |-> cpu_rdata == last_page)
    else begin
      error_count++;
      $error("FF46 read gave %h, expected %h", $sampled(cpu_rdata), $sampled(last_page));
    end

  active_on_start: assert property (@(posedge clk) disable iff (reset)
    start_write |=> dma_active)
    else begin
      error_count++;
      $error("dma_active did not rise on the start write");
    end

  active_length: assert property (@(posedge clk) disable iff (reset)
    dma_active == (cycles_left != 0))
    else begin
      error_count++;
      $error("dma_active is %b with %0d cycles left, phase %s",
             $sampled(dma_active), $sampled(cycles_left), expected_phase.name());
    end

  blocked_read: assert property (@(posedge clk) disable iff (reset)
    cpu_read_en && dma_active && (in_wram || in_oam) |-> cpu_rdata == blocked_read_value)
    else begin
      error_count++;
      $error("read of %h during copy gave %h", $sampled(cpu_addr.word), $sampled(cpu_rdata));
    end

  oam_contents: assert property (@(posedge clk) disable iff (reset)
    cpu_read_en && !dma_active && copy_done && in_oam |-> cpu_rdata == expected_oam)
    else begin
      error_count++;
      $error("oam read of %h gave %h, expected %h", $sampled(cpu_addr.word),
             $sampled(cpu_rdata), $sampled(expected_oam));
    end

endmodule

// ==== verif/dma_tb.sv ====
`timescale 1ns/100ps

module dma_tb;

  import dma_pkg::*;

  // two full copies, one partial copy, 512 fill writes, two oam readbacks and margin
  localparam int timeout_cycles = 4000;

  logic       clk;
  logic       reset;
  bus_addr_t  cpu_addr;
  logic [7:0] cpu_wdata;
  logic       cpu_write_en;
  logic       cpu_read_en;
  logic [7:0] cpu_rdata;
  logic       dma_active;

  logic [15:0] lfsr_state;
  int          cycle_count;

  dma_top UUT (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_write_en (cpu_write_en),
    .cpu_read_en  (cpu_read_en),
    .cpu_rdata    (cpu_rdata),
    .dma_active   (dma_active)
  );

  bind dma_top dma_assertions checks (
    .clk          (clk),
    .reset        (reset),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_write_en (cpu_write_en),
    .cpu_read_en  (cpu_read_en),
    .cpu_rdata    (cpu_rdata),
    .dma_active   (dma_active)
  );

  always #4 clk = ~clk;

  // ==========================================================================
  // stimulus helpers
  // ==========================================================================

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk);
    cpu_addr.word <= addr;
    cpu_wdata     <= data;
    cpu_write_en  <= 1'b1;
    cpu_read_en   <= 1'b0;
  endtask

  task automatic read_byte(input logic [15:0] addr);
    @(posedge clk);
    cpu_addr.word <= addr;
    cpu_write_en  <= 1'b0;
    cpu_read_en   <= 1'b1;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    cpu_write_en <= 1'b0;
    cpu_read_en  <= 1'b0;
  endtask

  task automatic wait_copy_done();
    do begin
      @(negedge clk);
    end while (dma_active);
  endtask

  task automatic read_all_oam();
    for (int i = 0; i < oam_length; i++) begin
      read_byte({oam_page, 8'(i)});
    end
    bus_idle();
  endtask

  // ==========================================================================
  // failure and timeout
  // ==========================================================================
  always @(UUT.checks.error_count) begin
    if (UUT.checks.error_count != 0) begin
      $display("Finished with errors");
      $display("ERROR at %0t ns: a check failed, see the assertion message", $time);
      $fatal(1, "stopping at the first failed check");
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Finished with errors");
      $fatal(1, "timeout: the run did not end within %0d cycles", timeout_cycles);
    end
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    logic [7:0] data;
    clk           = 1'b0;
    reset         = 1'b1;
    cpu_addr.word = 16'h0000;
    cpu_wdata     = 8'h00;
    cpu_write_en  = 1'b0;
    cpu_read_en   = 1'b0;
    cycle_count   = 0;
    lfsr_state    = 16'd76;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // source pages
    for (int p = 0; p < 2; p++) begin
      for (int off = 0; off < 256; off++) begin
        take_random_byte(data);
        write_byte({(p == 0) ? 8'hC3 : 8'hD0, 8'(off)}, data);
      end
    end
    read_byte(dma_reg_addr);

    // copy from C3 with cpu traffic on the blocked ranges
    write_byte(dma_reg_addr, 8'hC3);
    for (int k = 0; k < 48; k++) begin
      case (k % 3)
        0:       read_byte(dma_reg_addr);
        1:       read_byte({oam_page, 8'(k)});
        default: read_byte({8'hC3, 8'(k)});
      endcase
    end
    bus_idle();
    wait_copy_done();
    read_all_oam();

    // copy from D0, restarted halfway from C3
    write_byte(dma_reg_addr, 8'hD0);
    bus_idle();
    repeat (300) @(posedge clk);
    write_byte(dma_reg_addr, 8'hC3);
    bus_idle();
    read_byte(dma_reg_addr);
    bus_idle();
    wait_copy_done();
    read_all_oam();

    repeat (2) @(posedge clk);
    @(negedge clk);
    if (UUT.checks.error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "%0d checks failed", UUT.checks.error_count);
    end
  end

endmodule
